//--- Makefile
# Verilator build and run of the fsqrt testbench

LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
		--top-module fsqrt_tb --Mdir obj_dir -f compile.f
	./obj_dir/Vfsqrt_tb | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- compile.f
hw/fp_pkg.sv
hw/sqrt_pkg.sv
hw/sqrt_operand_if.sv
hw/sqrt_root_if.sv
hw/fsqrt_unpack.sv
hw/fsqrt_root.sv
hw/fsqrt_round.sv
hw/fsqrt_top.sv
sim/clock_gen.sv
sim/fsqrt_tb.sv

//--- hw/fp_pkg.sv
// ----------------------------------------------------------------------------
// IEEE 754 binary32 field layout, RISC-V rounding modes and the fflags word
// flag bit order is NV DZ OF UF NX, as in the RISC-V fflags CSR
// ----------------------------------------------------------------------------
`default_nettype none

package fp_pkg;

  localparam int EXP_W    = 8;
  localparam int MAN_W    = 23;
  localparam int SIG_W    = MAN_W + 1;   // stored fraction plus hidden bit
  localparam int FLAG_W   = 5;
  localparam int EXP_BIAS = 127;

  typedef logic [EXP_W-1:0]  exp_t;
  typedef logic [MAN_W-1:0]  man_t;
  typedef logic [SIG_W-1:0]  sig_t;
  typedef logic signed [9:0] sexp_t;     // unbiased, wide enough for denormals

  // encodings match the frm / rm field
  typedef enum logic [2:0] {
    RM_RNE = 3'd0,
    RM_RTZ = 3'd1,
    RM_RDN = 3'd2,
    RM_RUP = 3'd3,
    RM_RMM = 3'd4
  } rm_t;

  localparam int FLAG_NV = 4;  // invalid
  localparam int FLAG_DZ = 3;  // divide by zero
  localparam int FLAG_OF = 2;  // overflow
  localparam int FLAG_UF = 1;  // underflow
  localparam int FLAG_NX = 0;  // inexact

  localparam logic [31:0] CANON_NAN = 32'h7fc0_0000;
  localparam logic [31:0] POS_INF   = 32'h7f80_0000;

endpackage

`default_nettype wire

//--- hw/fsqrt_root.sv
// ----------------------------------------------------------------------------
// restoring digit-by-digit square root, one root bit per cycle
// a normal item gives rt.stb exactly ROOT_BITS cycles after acceptance
// special items bypass the loop and come out on the next cycle
// ----------------------------------------------------------------------------
`default_nettype none

module fsqrt_root import sqrt_pkg::*; #(
  parameter int ROOT_BITS = ROOT_BITS_DEFAULT
) (
  input  logic        clk,
  input  logic        rst,
  sqrt_operand_if.dst op,
  sqrt_root_if.src    rt
);

  localparam int RAD_W = 2 * ROOT_BITS;
  localparam int ACC_W = ROOT_BITS + 2;
  localparam int CNT_W = $clog2(ROOT_BITS);

  root_state_t          state;
  logic [CNT_W-1:0]     cnt;      // iterations already done
  logic                 start, last;
  logic [ACC_W-1:0]     ac, ac_cur, ac_sh, ac_next, trial;
  logic [RAD_W-1:0]     x, x_cur, x_next;
  logic [ROOT_BITS-1:0] q, q_cur, q_next;

  assign op.busy = (state == RS_ITER);
  assign start   = (state == RS_IDLE) && op.stb;
  assign last    = (cnt == CNT_W'(ROOT_BITS - 1));

  // the accept cycle already does the first iteration on op.rad
  assign ac_cur = (state == RS_IDLE) ? '0 : ac;
  assign x_cur  = (state == RS_IDLE) ? op.rad : x;
  assign q_cur  = (state == RS_IDLE) ? '0 : q;

  always_comb begin
    ac_sh  = {ac_cur[ROOT_BITS-1:0], x_cur[RAD_W-1 -: 2]};
    trial  = ac_sh - {q_cur, 2'b01};
    x_next = x_cur << 2;
    if (trial[ACC_W-1]) begin       // trial went negative, restore
      ac_next = ac_sh;
      q_next  = {q_cur[ROOT_BITS-2:0], 1'b0};
    end else begin
      ac_next = trial;
      q_next  = {q_cur[ROOT_BITS-2:0], 1'b1};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= RS_IDLE;
      cnt    <= '0;
      rt.stb <= 1'b0;
    end else begin
      rt.stb <= 1'b0;
      case (state)
        RS_IDLE: begin
          if (start && op.cls == CLS_NORMAL) begin
            state <= RS_ITER;
            cnt   <= CNT_W'(1);
          end else if (start) begin
            rt.stb <= 1'b1;          // zero, inf or NaN, nothing to compute
          end
        end
        RS_ITER: begin
          cnt <= cnt + 1'b1;
          if (last) begin
            state  <= RS_IDLE;
            rt.stb <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    ac <= ac_next;
    x  <= x_next;
    q  <= q_next;
    if (start) begin
      rt.cls     <= op.cls;
      rt.sign    <= op.sign;
      rt.exp     <= op.exp;
      rt.special <= op.special;
      rt.nv      <= op.nv;
      rt.rm      <= op.rm;
    end
    if (state == RS_ITER && last) begin
      rt.root   <= q_next;
      rt.rem_nz <= |ac_next;
    end
  end

endmodule

`default_nettype wire

//--- hw/fsqrt_round.sv
// ----------------------------------------------------------------------------
// rounding, packing and flags, one cycle after rt.stb
// a square root is never subnormal and never overflows, so only NV and NX
// can be raised; reserved rounding modes round as RNE
// ----------------------------------------------------------------------------
`default_nettype none

module fsqrt_round import fp_pkg::*, sqrt_pkg::*; #(
  parameter int ROOT_BITS = ROOT_BITS_DEFAULT
) (
  input  logic        clk,
  input  logic        rst,
  sqrt_root_if.dst    rt,
  output logic [31:0] z,
  output logic [4:0]  flags,
  output logic        z_stb
);

  sig_t                 sig;
  logic                 guard, rnd, sticky, inexact, inc;
  logic [ROOT_BITS-1:0] tail;
  logic [SIG_W:0]       sum;
  sexp_t                e_biased;
  exp_t                 e_field;
  man_t                 z_man;
  logic [31:0]          z_next;
  logic [FLAG_W-1:0]    flags_next;

  assign sig     = rt.root[ROOT_BITS-1 -: SIG_W];
  assign guard   = rt.root[ROOT_BITS-SIG_W-1];
  assign rnd     = rt.root[ROOT_BITS-SIG_W-2];
  assign tail    = rt.root << (SIG_W + 2);     // root bits below round, if any
  assign sticky  = rt.rem_nz | (|tail);
  assign inexact = guard | rnd | sticky;

  // finite results are always positive
  always_comb begin
    case (rt.rm)
      RM_RTZ, RM_RDN: inc = 1'b0;
      RM_RUP:  inc = inexact;
      RM_RMM:  inc = guard;                      // ties away
      default: inc = guard & (rnd | sticky | sig[0]);  // RNE, ties to even
    endcase
  end

  assign sum = {1'b0, sig} + {{SIG_W{1'b0}}, inc};

  // carry out means 1.111..1 rounded up to 10.000..0
  assign e_biased = rt.exp + sexp_t'(EXP_BIAS) + sexp_t'(sum[SIG_W]);
  assign e_field  = e_biased[EXP_W-1:0];
  assign z_man    = sum[SIG_W] ? sum[SIG_W-1:1] : sum[SIG_W-2:0];

  assign z_next = (rt.cls != CLS_NORMAL) ? rt.special : {rt.sign, e_field, z_man};

  always_comb begin
    flags_next = '0;
    if (rt.cls != CLS_NORMAL) begin
      flags_next[FLAG_NV] = rt.nv;
    end else begin
      flags_next[FLAG_NX] = inexact;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      z_stb <= 1'b0;
    end else begin
      z_stb <= rt.stb;
    end
  end

  // result holds until the next item
  always_ff @(posedge clk) begin
    if (rt.stb) begin
      z     <= z_next;
      flags <= flags_next;
    end
  end

endmodule

`default_nettype wire

//--- hw/fsqrt_top.sv
// ----------------------------------------------------------------------------
// binary32 square root, unpack -> root -> round
// latency ROOT_BITS+2 cycles for finite positive operands, 3 for special ones
// a_stb is ignored while busy is high; z_stb is a single-cycle pulse
// ----------------------------------------------------------------------------
`default_nettype none

module fsqrt_top import sqrt_pkg::*; #(
  parameter int ROOT_BITS = ROOT_BITS_DEFAULT
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] a,
  input  logic [2:0]  rm,
  input  logic        a_stb,
  output logic [31:0] z,
  output logic [4:0]  flags,
  output logic        z_stb,
  output logic        busy
);

  sqrt_operand_if #(.ROOT_BITS(ROOT_BITS)) i_op_if ();
  sqrt_root_if    #(.ROOT_BITS(ROOT_BITS)) i_rt_if ();

  fsqrt_unpack #(.ROOT_BITS(ROOT_BITS)) i_unpack (
    .clk   (clk),
    .rst   (rst),
    .a     (a),
    .rm    (rm),
    .a_stb (a_stb),
    .busy  (busy),
    .op    (i_op_if.src)
  );

  fsqrt_root #(.ROOT_BITS(ROOT_BITS)) i_root (
    .clk (clk),
    .rst (rst),
    .op  (i_op_if.dst),
    .rt  (i_rt_if.src)
  );

  fsqrt_round #(.ROOT_BITS(ROOT_BITS)) i_round (
    .clk   (clk),
    .rst   (rst),
    .rt    (i_rt_if.dst),
    .z     (z),
    .flags (flags),
    .z_stb (z_stb)
  );

endmodule

`default_nettype wire

//--- hw/fsqrt_unpack.sv
// ----------------------------------------------------------------------------
// operand decode, denormal normalisation and radicand alignment
// an a_stb while busy is high is dropped, there is no back-pressure
// negative operands and sNaN raise NV, every NaN result is 7fc00000
// ----------------------------------------------------------------------------
`default_nettype none

module fsqrt_unpack import fp_pkg::*, sqrt_pkg::*; #(
  parameter int ROOT_BITS = ROOT_BITS_DEFAULT
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] a,
  input  logic [2:0]  rm,
  input  logic        a_stb,
  output logic        busy,
  sqrt_operand_if.src op
);

  localparam int RAD_W = 2 * ROOT_BITS;

  // leading zeros of a significand, highest set bit wins
  function automatic logic [4:0] lead_zeros(sig_t v);
    logic [4:0] n;
    n = 5'd0;
    for (int i = 0; i < SIG_W; i++) begin
      if (v[i]) n = 5'(SIG_W - 1 - i);
    end
    return n;
  endfunction

  exp_t             a_exp;
  man_t             a_man;
  logic             is_nan, is_inf, is_zero, is_den;
  logic [4:0]       lz;
  sig_t             sig;
  sexp_t            e_unb;
  logic [RAD_W-1:0] rad;
  op_class_t        cls;
  logic [31:0]      special;
  logic             nv;
  logic             accept;

  assign a_exp   = a[30:23];
  assign a_man   = a[22:0];
  assign is_nan  = (a_exp == '1) && (a_man != '0);
  assign is_inf  = (a_exp == '1) && (a_man == '0);
  assign is_zero = (a_exp == '0) && (a_man == '0);
  assign is_den  = (a_exp == '0) && (a_man != '0);

  assign lz    = lead_zeros({1'b0, a_man});
  assign sig   = is_den ? (sig_t'({1'b0, a_man}) << lz) : {1'b1, a_man};
  assign e_unb = is_den ? sexp_t'(-126) - sexp_t'(lz)
                        : sexp_t'(a_exp) - sexp_t'(EXP_BIAS);

  // odd exponent: one extra left shift so that halving is exact
  assign rad = e_unb[0] ? {sig, {(RAD_W-SIG_W){1'b0}}}
                        : {1'b0, sig, {(RAD_W-SIG_W-1){1'b0}}};

  always_comb begin
    cls     = CLS_NORMAL;
    special = CANON_NAN;
    nv      = 1'b0;
    if (is_nan) begin
      cls = CLS_NAN;
      nv  = ~a_man[MAN_W-1];         // signalling NaN only
    end else if (is_zero) begin
      cls     = CLS_ZERO;
      special = {a[31], 31'd0};      // sqrt(-0) is -0
    end else if (a[31]) begin
      cls = CLS_NAN;                 // negative number or -inf
      nv  = 1'b1;
    end else if (is_inf) begin
      cls     = CLS_INF;
      special = POS_INF;
    end
  end

  assign busy   = op.stb | op.busy;
  assign accept = a_stb & ~busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      op.stb <= 1'b0;
    end else begin
      op.stb <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op.cls     <= cls;
      op.sign    <= a[31];
      op.exp     <= e_unb >>> 1;     // floor, matches the odd-exponent shift
      op.rad     <= rad;
      op.special <= special;
      op.nv      <= nv;
      op.rm      <= rm_t'(rm);
    end
  end

endmodule

`default_nettype wire

//--- hw/sqrt_operand_if.sv
// ----------------------------------------------------------------------------
// unpacked operand from unpack stage to root stage
// stb is a single-cycle pulse, busy runs back from the root stage
// ----------------------------------------------------------------------------
`default_nettype none

interface sqrt_operand_if import fp_pkg::*, sqrt_pkg::*; #(
  parameter int ROOT_BITS = ROOT_BITS_DEFAULT
) ();

  logic                   stb;
  op_class_t              cls;
  logic                   sign;
  sexp_t                  exp;      // already halved
  logic [2*ROOT_BITS-1:0] rad;      // significand aligned for an even exponent
  logic [31:0]            special;
  logic                   nv;
  rm_t                    rm;
  logic                   busy;

  modport src (output stb, cls, sign, exp, rad, special, nv, rm, input busy);
  modport dst (input stb, cls, sign, exp, rad, special, nv, rm, output busy);

endinterface

`default_nettype wire

//--- hw/sqrt_pkg.sv
// ----------------------------------------------------------------------------
// square root datapath types
// ROOT_BITS must be at least 26 (24 significand bits, guard, round)
// ----------------------------------------------------------------------------
`default_nettype none

package sqrt_pkg;

  // anything other than CLS_NORMAL means the special word is the result
  typedef enum logic [1:0] {
    CLS_NORMAL = 2'd0,
    CLS_ZERO   = 2'd1,
    CLS_INF    = 2'd2,
    CLS_NAN    = 2'd3
  } op_class_t;

  typedef enum logic {
    RS_IDLE = 1'b0,
    RS_ITER = 1'b1
  } root_state_t;

  // bits beyond 26 only feed the sticky bit
  localparam int ROOT_BITS_DEFAULT = 26;

endpackage

`default_nettype wire

//--- hw/sqrt_root_if.sv
// ----------------------------------------------------------------------------
// root result from root stage to round stage
// payload is only valid on the cycle stb is high
// ----------------------------------------------------------------------------
`default_nettype none

interface sqrt_root_if import fp_pkg::*, sqrt_pkg::*; #(
  parameter int ROOT_BITS = ROOT_BITS_DEFAULT
) ();

  logic                 stb;
  op_class_t            cls;
  logic                 sign;
  sexp_t                exp;
  logic [31:0]          special;
  logic                 nv;
  rm_t                  rm;
  logic [ROOT_BITS-1:0] root;     // msb is the integer bit
  logic                 rem_nz;

  modport src (output stb, cls, sign, exp, special, nv, rm, root, rem_nz);
  modport dst (input stb, cls, sign, exp, special, nv, rm, root, rem_nz);

endinterface

`default_nettype wire

//--- sim/clock_gen.sv
// ----------------------------------------------------------------------------
// testbench clock and synchronous reset
// rst falls 1 ns after the last reset edge, like all other stimulus
// ----------------------------------------------------------------------------
`default_nettype none

module clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

`default_nettype wire

//--- sim/fsqrt_tb.sv
// ----------------------------------------------------------------------------
// directed tests for the binary32 square root, default ROOT_BITS of 26
// expected values come from a double precision model, rounded to single
// inputs change 1 ns after the rising edge, outputs are sampled there too
// ----------------------------------------------------------------------------
`default_nettype none

module fsqrt_tb import fp_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int LAT_NORMAL  = 28;     // ROOT_BITS + 2
  localparam int LAT_SPECIAL = 3;
  localparam int OP_LIMIT    = 64;     // per-operation wait
  localparam int MAX_CYCLES  = 20000;

  logic        clk, rst;
  logic [31:0] a, z;
  logic [2:0]  rm;
  logic [4:0]  flags;
  logic        a_stb, z_stb, busy;
  int          n_pass, n_fail, cycle_cnt;

  clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(2)) i_clock_gen (.clk(clk), .rst(rst));

  fsqrt_top i_fsqrt_top (
    .clk   (clk),
    .rst   (rst),
    .a     (a),
    .rm    (rm),
    .a_stb (a_stb),
    .z     (z),
    .flags (flags),
    .z_stb (z_stb),
    .busy  (busy)
  );

  // exact real value of a binary32 word, denormals included
  function automatic real to_double(logic [31:0] f);
    logic [23:0] m;
    int          e;
    m = {1'b1, f[22:0]};
    e = int'(f[30:23]) - 127;
    if (f[30:23] == 8'd0) begin
      if (f[22:0] == 23'd0) return 0.0;
      m = {1'b0, f[22:0]};
      e = -126;
      while (!m[23]) begin
        m = m << 1;
        e--;
      end
    end
    return $bitstoreal({f[31], 11'(e + 1023), m[22:0], 29'd0});
  endfunction

  // round a positive normal double to binary32, ties to even
  function automatic logic [31:0] round_to_single(real r);
    logic [63:0] d;
    logic [24:0] keep;
    int          e;
    d    = $realtobits(r);
    e    = int'(d[62:52]) - 1023 + 127;
    keep = {2'b01, d[51:29]};
    if (d[28] && ((|d[27:0]) || keep[0])) keep = keep + 25'd1;
    if (keep[24]) begin              // rounded up into the next binade
      e++;
      keep = keep >> 1;
    end
    return {d[63], 8'(e), keep[22:0]};
  endfunction

  function automatic logic [31:0] sqrt_model(logic [31:0] f);
    return round_to_single($sqrt(to_double(f)));
  endfunction

  task automatic report_error(string msg);
    $display("error %0d ns: %s", $time, msg);
    n_fail++;
  endtask

  task automatic report_test(string name, int ops, int fail0);
    $display("%-18s %4d operations, %0d errors", name, ops, n_fail - fail0);
  endtask

  // one operation from issue to z_stb, lat counts edges from the drive point
  task automatic run_op(input logic [31:0] op_a, input logic [2:0] op_rm,
                        output logic [31:0] res, output logic [4:0] fl,
                        output int lat, output bit ok);
    while (busy) begin
      @(posedge clk);
      #1;
    end
    a     = op_a;
    rm    = op_rm;
    a_stb = 1'b1;
    lat   = 0;
    ok    = 1'b0;
    while (!ok && lat < OP_LIMIT) begin
      @(posedge clk);
      #1;
      a_stb = 1'b0;
      lat++;
      ok = z_stb;
    end
    res = z;
    fl  = flags;
    if (!ok) begin
      $display("no result came back within %0d cycles for operand %h", OP_LIMIT, op_a);
      n_fail++;
    end
  endtask

  task automatic exact_squares();
    logic [31:0] sq_in [5]  = '{32'h3f80_0000, 32'h4080_0000, 32'h4010_0000,
                                32'h3e80_0000, 32'h0080_0000};
    logic [31:0] sq_out [5] = '{32'h3f80_0000, 32'h4000_0000, 32'h3fc0_0000,
                                32'h3f00_0000, 32'h2000_0000};   // 2^-126 -> 2^-63
    logic [31:0] zg;
    logic [4:0]  fg;
    int          lat, fail0;
    bit          ok;
    fail0 = n_fail;
    for (int i = 0; i < 5; i++) begin
      for (int m = 0; m < 5; m++) begin
        run_op(sq_in[i], 3'(m), zg, fg, lat, ok);
        if (ok && (zg !== sq_out[i] || fg !== 5'd0 || lat != LAT_NORMAL))
          report_error($sformatf("sqrt(%h) rm %0d gave %h flags %b after %0d cycles",
                                 sq_in[i], m, zg, fg, lat));
        else if (ok) n_pass++;
      end
    end
    report_test("exact squares", 25, fail0);
  endtask

  task automatic special_operands();
    logic [31:0] sp_in [7]  = '{32'h0000_0000, 32'h8000_0000, 32'h7f80_0000, 32'h7fc1_2345,
                                32'h7f81_2345, 32'hbf80_0000, 32'hff80_0000};
    logic [31:0] sp_out [7] = '{32'h0000_0000, 32'h8000_0000, 32'h7f80_0000, CANON_NAN,
                                CANON_NAN, CANON_NAN, CANON_NAN};
    bit          sp_nv [7]  = '{0, 0, 0, 0, 1, 1, 1};
    logic [31:0] zg;
    logic [4:0]  fg, fe;
    int          lat, fail0;
    bit          ok;
    fail0 = n_fail;
    for (int i = 0; i < 7; i++) begin
      fe          = '0;
      fe[FLAG_NV] = sp_nv[i];
      run_op(sp_in[i], RM_RNE, zg, fg, lat, ok);
      if (ok && (zg !== sp_out[i] || fg !== fe || lat != LAT_SPECIAL))
        report_error($sformatf("sqrt(%h) gave %h flags %b after %0d cycles, expected %h %b",
                               sp_in[i], zg, fg, lat, sp_out[i], fe));
      else if (ok) n_pass++;
    end
    report_test("special operands", 7, fail0);
  endtask

  // normal (exp field nonzero) or denormal positive operands against the model
  task automatic random_rne(string name, int count, bit denormal);
    logic [31:0] op, zg, ze;
    logic [4:0]  fg, fe;
    int          lat, fail0;
    bit          ok;
    real         rv;
    fail0 = n_fail;
    for (int i = 0; i < count; i++) begin
      op = {1'b0, 8'($urandom_range(254, 1)), 23'($urandom)};
      if (denormal) op[30:23] = 8'd0;
      if (op[30:0] == 31'd0) op[0] = 1'b1;
      ze          = sqrt_model(op);
      rv          = to_double(ze);
      fe          = '0;
      fe[FLAG_NX] = (rv * rv != to_double(op));
      run_op(op, RM_RNE, zg, fg, lat, ok);
      if (ok && (zg !== ze || fg !== fe || zg[30:23] == 8'd0))
        report_error($sformatf("sqrt(%h) gave %h flags %b, expected %h %b",
                               op, zg, fg, ze, fe));
      else if (ok) n_pass++;
    end
    report_test(name, count, fail0);
  endtask

  task automatic random_modes();
    rm_t         modes [4] = '{RM_RTZ, RM_RDN, RM_RUP, RM_RMM};
    logic [31:0] op, zg;
    logic [4:0]  fg, fe;
    int          lat, fail0;
    bit          ok, good;
    real         av, r, r_up, r_dn;
    fail0 = n_fail;
    foreach (modes[k]) begin
      for (int i = 0; i < 50; i++) begin
        op = {1'b0, 8'($urandom_range(254, 1)), 23'($urandom)};
        run_op(op, modes[k], zg, fg, lat, ok);
        av   = to_double(op);
        r    = to_double(zg);
        r_up = to_double(zg + 32'd1);   // neighbours one ulp away
        r_dn = to_double(zg - 32'd1);
        case (modes[k])
          RM_RUP:  good = (r_dn * r_dn < av) && (av <= r * r);
          RM_RMM:  good = (zg === sqrt_model(op));   // no exact ties in a root
          default: good = (r * r <= av) && (av < r_up * r_up);
        endcase
        fe          = '0;
        fe[FLAG_NX] = (r * r != av);
        if (ok && (!good || fg !== fe))
          report_error($sformatf("sqrt(%h) rm %0d gave %h flags %b, out of bounds",
                                 op, modes[k], zg, fg));
        else if (ok) n_pass++;
      end
    end
    report_test("random modes", 200, fail0);
  endtask

  // strobes while busy must vanish, an issue on the falling busy edge must not
  task automatic busy_drops();
    logic [31:0] ops [3]   = '{32'h4080_0000, 32'h4010_0000, 32'h7f80_0000};
    logic [31:0] wants [3] = '{32'h4000_0000, 32'h3fc0_0000, 32'h7f80_0000};
    logic [31:0] got_q [$];
    int          issued, fall_cyc, fail0;
    bit          was_busy, busy_at_accept;
    fail0 = n_fail;
    while (busy) begin
      @(posedge clk);
      #1;
    end
    a              = ops[0];
    rm             = RM_RNE;
    a_stb          = 1'b1;
    issued         = 1;
    was_busy       = 1'b0;
    busy_at_accept = 1'b0;
    fall_cyc       = -1;
    for (int cyc = 0; cyc < 120; cyc++) begin
      @(posedge clk);
      #1;
      a_stb = 1'b0;
      if (z_stb) got_q.push_back(z);
      if (cyc == 0) busy_at_accept = busy;
      if (!busy && was_busy && fall_cyc < 0) fall_cyc = cyc;   // first item done
      if (busy) begin
        was_busy = 1'b1;
        if (cyc % 2 == 1) begin
          a     = 32'h4110_0000;      // 9.0, would come back as 3.0
          a_stb = 1'b1;
        end
      end else if (was_busy && issued < 3) begin
        a        = ops[issued];
        a_stb    = 1'b1;
        issued++;
        was_busy = 1'b0;
      end
    end
    // busy covers the first item from the accept until one cycle before z_stb
    if (!busy_at_accept || fall_cyc != LAT_NORMAL - 2)
      report_error($sformatf("busy %b after accept, fell at cycle %0d, expected 1 and %0d",
                             busy_at_accept, fall_cyc, LAT_NORMAL - 2));
    else n_pass++;
    if (got_q.size() != 3) begin
      report_error($sformatf("%0d results for 3 accepted strobes", got_q.size()));
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (got_q[i] !== wants[i])
          report_error($sformatf("result %0d is %h, expected %h", i, got_q[i], wants[i]));
        else n_pass++;
      end
    end
    report_test("busy and drops", 4, fail0);
  endtask

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: the run did not end within %0d cycles", MAX_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin : main
    a      = '0;
    rm     = '0;
    a_stb  = 1'b0;
    n_pass = 0;
    n_fail = 0;
    void'($urandom(32'hde8d4f47));
    do @(posedge clk); while (rst);
    #1;
    exact_squares();
    special_operands();
    random_rne("random rne", 150, 1'b0);
    random_modes();
    random_rne("denormal operands", 40, 1'b1);
    busy_drops();
    $display("checks passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
